//--- flist.f
rtl/sysDrvPkg.sv
rtl/cmdDecode.sv
rtl/flagBank.sv
rtl/backdoorMover.sv
rtl/rspFormat.sv
rtl/sysDriverCtrl.sv
test/tbClock.sv
test/memModels.sv
test/sysDriverCtrl_tb.sv

//--- rtl/backdoorMover.sv
//--------------------------------------------------------------------------
// Backdoor memory mover
// One 64-bit word access to main memory, or eight little-endian byte
// accesses to flash, selected by the backdoor select level
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module backdoorMover (
  input  logic                          clk,
  input  logic                          reset_i,
  input  logic                          opValid_i,
  input  sysDrvPkg::decodedOp_t         op_i,
  input  logic                          backdoorSel_i,
  output logic                          mainReqValid_o,
  output sysDrvPkg::mainMemReq_t        mainReq_o,
  input  logic [sysDrvPkg::DATA_W-1:0]  mainRdata_i,
  output logic                          flashReqValid_o,
  output sysDrvPkg::flashReq_t          flashReq_o,
  input  logic [7:0]                    flashRdata_i,
  output logic                          memDone_o,
  output logic [sysDrvPkg::DATA_W-1:0]  memRdata_o
);

  import sysDrvPkg::*;

  moverState_e           state;
  logic [BYTE_CNT_W-1:0] byteCnt;
  logic [BYTE_CNT_W-1:0] prevIdx;
  logic [DATA_W-9:0]     flashLow;
  logic                  isWrite;
  logic                  isMemOp;
  logic                  lastByte;

  assign isWrite  = (op_i.opcode == OP_MEM_WRITE);
  assign isMemOp  = isWrite || (op_i.opcode == OP_MEM_READ);
  assign lastByte = (byteCnt == BYTE_CNT_W'(BYTES_PER_WORD - 1));
  // Byte whose read data returns this cycle
  assign prevIdx  = byteCnt - BYTE_CNT_W'(1);

  //------------------------------------------------------------------------
  // Sequencer
  //------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset_i) begin
      state   <= MV_IDLE;
      byteCnt <= '0;
    end else begin
      case (state)
        MV_IDLE: begin
          byteCnt <= '0;
          if (opValid_i && isMemOp) begin
            state <= backdoorSel_i ? MV_FLASH : MV_MAIN;
          end
        end
        MV_MAIN:       state <= isWrite ? MV_DONE : MV_MAIN_WAIT;
        MV_MAIN_WAIT:  state <= MV_DONE;
        MV_FLASH: begin
          byteCnt <= byteCnt + BYTE_CNT_W'(1);
          if (lastByte) begin
            state <= isWrite ? MV_DONE : MV_FLASH_WAIT;
          end
        end
        MV_FLASH_WAIT: state <= MV_DONE;
        // Response goes out while the mover settles back to idle
        MV_DONE:       state <= MV_IDLE;
        default:       state <= MV_IDLE;
      endcase
    end
  end

  // Flash read bytes arrive one cycle behind their request
  always_ff @(posedge clk) begin
    if ((state == MV_FLASH) && !isWrite && (byteCnt != '0)) begin
      flashLow[{prevIdx, 3'b000} +: 8] <= flashRdata_i;
    end
  end

  //------------------------------------------------------------------------
  // Memory requests
  //------------------------------------------------------------------------
  assign mainReqValid_o     = (state == MV_MAIN);
  assign mainReq_o.write    = isWrite;
  assign mainReq_o.wordAddr = op_i.addr[ADDR_W-1 -: WORD_ADDR_W];
  assign mainReq_o.wdata    = op_i.memData;

  // Byte lane follows the byte count, little endian
  assign flashReqValid_o    = (state == MV_FLASH);
  assign flashReq_o.write   = isWrite;
  assign flashReq_o.addr    = op_i.addr + ADDR_W'(byteCnt);
  assign flashReq_o.wdata   = op_i.memData[{byteCnt, 3'b000} +: 8];

  // Completion, writes finish with their last request
  assign memDone_o = ((state == MV_MAIN) && isWrite) ||
                     (state == MV_MAIN_WAIT) ||
                     ((state == MV_FLASH) && lastByte && isWrite) ||
                     (state == MV_FLASH_WAIT);

  // Top byte of a flash word comes straight from the model
  assign memRdata_o = (state == MV_MAIN_WAIT) ? mainRdata_i : {flashRdata_i, flashLow};

endmodule

//--- rtl/cmdDecode.sv
//--------------------------------------------------------------------------
// Command decode stage
// Captures one command strobe and produces the decoded operation with
// the flag range mask, the aligned flag data and the range error
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module cmdDecode (
  input  logic                   clk,
  input  logic                   reset_i,
  input  logic                   cmdValid_i,
  input  sysDrvPkg::cmd_t        cmd_i,
  output logic                   opValid_o,
  output sysDrvPkg::decodedOp_t  op_o
);

  import sysDrvPkg::*;

  decodedOp_t decoded;

  always_comb begin
    logic [FLAG_W-1:0]    hiMask;
    logic [FLAG_W-1:0]    loMask;
    logic [BIT_IDX_W-1:0] hiShift;
    logic                 isFlag;

    isFlag  = (cmd_i.opcode == OP_FLAG_WRITE) || (cmd_i.opcode == OP_FLAG_READ);
    hiShift = BIT_IDX_W'(FLAG_W - 1) - cmd_i.msb;

    // Ones from bit msb down, ones from bit lsb up
    hiMask  = {FLAG_W{1'b1}} >> hiShift;
    loMask  = {FLAG_W{1'b1}} << cmd_i.lsb;

    decoded.opcode   = cmd_i.opcode;
    decoded.addr     = cmd_i.addr;
    decoded.lsb      = cmd_i.lsb;
    decoded.memData  = cmd_i.data;
    // Range check only matters for flag access
    decoded.err      = isFlag && (cmd_i.msb < cmd_i.lsb);
    decoded.flagMask = isFlag ? (hiMask & loMask) : '0;
    // Field value moved up to its position in the vector
    decoded.flagData = cmd_i.data << cmd_i.lsb;
  end

  // Strobe control
  always_ff @(posedge clk) begin
    if (reset_i) begin
      opValid_o <= 1'b0;
    end else begin
      opValid_o <= cmdValid_i;
    end
  end

  // Decoded operation stays put until the next strobe
  always_ff @(posedge clk) begin
    if (cmdValid_i) begin
      op_o <= decoded;
    end
  end

endmodule

//--- rtl/flagBank.sv
//--------------------------------------------------------------------------
// Debug-flag bank
// Holds the flag vector, executes the self-clearing command bits and
// keeps the control levels they set
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module flagBank (
  input  logic                      clk,
  input  logic                      reset_i,
  input  logic                      opValid_i,
  input  sysDrvPkg::decodedOp_t     op_i,
  output logic                      flagDone_o,
  output logic [sysDrvPkg::FLAG_W-1:0] flagVec_o,
  output sysDrvPkg::ctrlFlags_t     ctrl_o
);

  import sysDrvPkg::*;

  logic              isFlagOp;
  logic              doWrite;
  logic [FLAG_W-1:0] vecNext;
  ctrlFlags_t        ctrlNext;

  assign isFlagOp = (op_i.opcode == OP_FLAG_WRITE) || (op_i.opcode == OP_FLAG_READ);
  assign doWrite  = opValid_i && (op_i.opcode == OP_FLAG_WRITE) && !op_i.err;

  //------------------------------------------------------------------------
  // Merge and command-bit side effects
  //------------------------------------------------------------------------
  always_comb begin
    logic [FLAG_W-1:0] work;

    work     = (flagVec_o & ~op_i.flagMask) | (op_i.flagData & op_i.flagMask);
    ctrlNext = ctrl_o;

    // Order matters, a get after a set reports the new select
    if (work[FLG_SET_BACKDOOR_SEL]) begin
      ctrlNext.backdoorSel = work[PAT_LO];
    end
    if (work[FLG_GET_BACKDOOR_SEL]) begin
      work[PAT_HI:PAT_LO] = (PAT_HI - PAT_LO + 1)'(ctrlNext.backdoorSel);
    end
    if (work[FLG_SET_PROG_LOADED]) begin
      ctrlNext.programLoaded = work[PAT_LO];
    end

    // Memory trace levels
    if (work[FLG_DIS_MEM_LOG]) begin
      ctrlNext.wrTrace = 1'b0;
      ctrlNext.rdTrace = 1'b0;
    end
    if (work[FLG_EN_MEM_LOG]) begin
      ctrlNext.wrTrace = 1'b1;
      ctrlNext.rdTrace = 1'b1;
    end
    if (work[FLG_EN_MEMWR_LOG]) begin
      ctrlNext.wrTrace = 1'b1;
    end
    if (work[FLG_EN_MEMRD_LOG]) begin
      ctrlNext.rdTrace = 1'b1;
    end

    // Loopback levels follow the pattern bit
    if (work[FLG_UART_LOOPBACK]) begin
      ctrlNext.uartLoopback = work[PAT_LO];
    end
    if (work[FLG_SPI_LOOPBACK]) begin
      ctrlNext.spiLoopback = work[PAT_LO];
    end

    // Command bits never stay set
    vecNext = work & ~CMD_FLAG_MASK;
  end

  //------------------------------------------------------------------------
  // State update
  //------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset_i) begin
      flagDone_o <= 1'b0;
      flagVec_o  <= FLAG_RESET;
      ctrl_o     <= CTRL_RESET;
    end else begin
      // Range errors answer through this path as well
      flagDone_o <= opValid_i && (isFlagOp || op_i.err);
      if (doWrite) begin
        flagVec_o <= vecNext;
        ctrl_o    <= ctrlNext;
      end
    end
  end

endmodule

//--- rtl/rspFormat.sv
//--------------------------------------------------------------------------
// Response formatter
// Builds the read data for the finished operation and issues the
// one-cycle response pulse
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module rspFormat (
  input  logic                          clk,
  input  logic                          reset_i,
  input  logic                          flagDone_i,
  input  logic [sysDrvPkg::FLAG_W-1:0]  flagVec_i,
  input  logic                          memDone_i,
  input  logic [sysDrvPkg::DATA_W-1:0]  memRdata_i,
  input  sysDrvPkg::decodedOp_t         op_i,
  output logic                          rspValid_o,
  output sysDrvPkg::rsp_t               rsp_o
);

  import sysDrvPkg::*;

  rsp_t rspNext;
  logic done;

  assign done = flagDone_i || memDone_i;

  always_comb begin
    rspNext.err = op_i.err;
    case (op_i.opcode)
      // Selected range lands at bit 0
      OP_FLAG_READ: rspNext.data = (flagVec_i & op_i.flagMask) >> op_i.lsb;
      OP_MEM_READ:  rspNext.data = memRdata_i;
      default:      rspNext.data = '0;
    endcase
    if (op_i.err) begin
      rspNext.data = '0;
    end
  end

  always_ff @(posedge clk) begin
    if (reset_i) begin
      rspValid_o <= 1'b0;
    end else begin
      rspValid_o <= done;
    end
  end

  always_ff @(posedge clk) begin
    if (done) begin
      rsp_o <= rspNext;
    end
  end

endmodule

//--- rtl/sysDriverCtrl.sv
//--------------------------------------------------------------------------
// System driver control, top level
// Command decode, flag bank and backdoor mover in parallel, then the
// response formatter
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module sysDriverCtrl (
  input  logic                          clk,
  input  logic                          reset_i,
  // Command and response
  input  logic                          cmdValid_i,
  input  sysDrvPkg::cmd_t               cmd_i,
  output logic                          rspValid_o,
  output sysDrvPkg::rsp_t               rsp_o,
  output sysDrvPkg::ctrlFlags_t         ctrl_o,
  // Main memory port
  output logic                          mainReqValid_o,
  output sysDrvPkg::mainMemReq_t        mainReq_o,
  input  logic [sysDrvPkg::DATA_W-1:0]  mainRdata_i,
  // Flash port
  output logic                          flashReqValid_o,
  output sysDrvPkg::flashReq_t          flashReq_o,
  input  logic [7:0]                    flashRdata_i
);

  import sysDrvPkg::*;

  logic              opValid;
  decodedOp_t        op;
  logic              flagDone;
  logic [FLAG_W-1:0] flagVec;
  logic              memDone;
  logic [DATA_W-1:0] memRdata;

  cmdDecode decode_inst (
    .clk        (clk),
    .reset_i    (reset_i),
    .cmdValid_i (cmdValid_i),
    .cmd_i      (cmd_i),
    .opValid_o  (opValid),
    .op_o       (op)
  );

  // Execute stage, each unit ignores the other unit's opcodes
  flagBank flags_inst (
    .clk        (clk),
    .reset_i    (reset_i),
    .opValid_i  (opValid),
    .op_i       (op),
    .flagDone_o (flagDone),
    .flagVec_o  (flagVec),
    .ctrl_o     (ctrl_o)
  );

  backdoorMover mover_inst (
    .clk             (clk),
    .reset_i         (reset_i),
    .opValid_i       (opValid),
    .op_i            (op),
    .backdoorSel_i   (ctrl_o.backdoorSel),
    .mainReqValid_o  (mainReqValid_o),
    .mainReq_o       (mainReq_o),
    .mainRdata_i     (mainRdata_i),
    .flashReqValid_o (flashReqValid_o),
    .flashReq_o      (flashReq_o),
    .flashRdata_i    (flashRdata_i),
    .memDone_o       (memDone),
    .memRdata_o      (memRdata)
  );

  rspFormat result_inst (
    .clk        (clk),
    .reset_i    (reset_i),
    .flagDone_i (flagDone),
    .flagVec_i  (flagVec),
    .memDone_i  (memDone),
    .memRdata_i (memRdata),
    .op_i       (op),
    .rspValid_o (rspValid_o),
    .rsp_o      (rsp_o)
  );

endmodule

//--- rtl/sysDrvPkg.sv
//--------------------------------------------------------------------------
// System driver control package
// Widths, debug-flag bit map, reset values, opcodes and the structs
// shared by the decode, execute and result stages
//--------------------------------------------------------------------------

package sysDrvPkg;

  // Datapath widths
  localparam int FLAG_W         = 64;
  localparam int DATA_W         = 64;
  localparam int ADDR_W         = 32;
  localparam int WORD_ADDR_W    = 29;
  localparam int BYTES_PER_WORD = 8;
  localparam int BIT_IDX_W      = 6;
  localparam int BYTE_CNT_W     = 3;

  // Pattern field, argument and result of command bits
  localparam int PAT_LO = 0;
  localparam int PAT_HI = 15;

  // Self-clearing command bits
  localparam int FLG_SET_BACKDOOR_SEL = 32;
  localparam int FLG_GET_BACKDOOR_SEL = 33;
  localparam int FLG_SET_PROG_LOADED  = 34;
  localparam int FLG_DIS_MEM_LOG      = 35;
  localparam int FLG_EN_MEM_LOG       = 36;
  localparam int FLG_EN_MEMWR_LOG     = 37;
  localparam int FLG_EN_MEMRD_LOG     = 38;
  localparam int FLG_UART_LOOPBACK    = 39;
  localparam int FLG_SPI_LOOPBACK     = 40;

  localparam logic [FLAG_W-1:0] CMD_FLAG_MASK =
    (FLAG_W'(1) << FLG_SET_BACKDOOR_SEL) | (FLAG_W'(1) << FLG_GET_BACKDOOR_SEL) |
    (FLAG_W'(1) << FLG_SET_PROG_LOADED)  | (FLAG_W'(1) << FLG_DIS_MEM_LOG) |
    (FLAG_W'(1) << FLG_EN_MEM_LOG)       | (FLAG_W'(1) << FLG_EN_MEMWR_LOG) |
    (FLAG_W'(1) << FLG_EN_MEMRD_LOG)     | (FLAG_W'(1) << FLG_UART_LOOPBACK) |
    (FLAG_W'(1) << FLG_SPI_LOOPBACK);

  typedef enum logic [1:0] {
    OP_MEM_WRITE  = 2'd0,
    OP_MEM_READ   = 2'd1,
    OP_FLAG_WRITE = 2'd2,
    OP_FLAG_READ  = 2'd3
  } opcode_e;

  typedef enum logic [2:0] {
    MV_IDLE, MV_MAIN, MV_MAIN_WAIT, MV_FLASH, MV_FLASH_WAIT, MV_DONE
  } moverState_e;

  typedef struct packed {
    opcode_e                opcode;
    logic [ADDR_W-1:0]      addr;
    logic [BIT_IDX_W-1:0]   msb;
    logic [BIT_IDX_W-1:0]   lsb;
    logic [DATA_W-1:0]      data;
  } cmd_t;

  typedef struct packed {
    opcode_e                opcode;
    logic                   err;
    logic [ADDR_W-1:0]      addr;
    logic [BIT_IDX_W-1:0]   lsb;
    logic [FLAG_W-1:0]      flagMask;
    logic [FLAG_W-1:0]      flagData;
    logic [DATA_W-1:0]      memData;
  } decodedOp_t;

  typedef struct packed {
    logic                   write;
    logic [WORD_ADDR_W-1:0] wordAddr;
    logic [DATA_W-1:0]      wdata;
  } mainMemReq_t;

  typedef struct packed {
    logic                   write;
    logic [ADDR_W-1:0]      addr;
    logic [7:0]             wdata;
  } flashReq_t;

  typedef struct packed {
    logic backdoorSel;
    logic programLoaded;
    logic wrTrace;
    logic rdTrace;
    logic uartLoopback;
    logic spiLoopback;
  } ctrlFlags_t;

  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic              err;
  } rsp_t;

  // Levels after reset, loopbacks default on
  localparam logic [FLAG_W-1:0] FLAG_RESET = '0;
  localparam ctrlFlags_t CTRL_RESET = '{
    backdoorSel:   1'b0,
    programLoaded: 1'b0,
    wrTrace:       1'b0,
    rdTrace:       1'b0,
    uartLoopback:  1'b1,
    spiLoopback:   1'b1
  };

endpackage

//--- test/memModels.sv
//--------------------------------------------------------------------------
// Behavioral memory models
// Main memory of 64-bit words and a byte-wide flash, both with read
// data registered one cycle after the request strobe
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module memModels (
  input  logic                          clk,
  input  logic                          mainReqValid_i,
  input  sysDrvPkg::mainMemReq_t        mainReq_i,
  output logic [sysDrvPkg::DATA_W-1:0]  mainRdata_o,
  input  logic                          flashReqValid_i,
  input  sysDrvPkg::flashReq_t          flashReq_i,
  output logic [7:0]                    flashRdata_o
);

  import sysDrvPkg::*;

  // Only the low address bits are decoded
  logic [DATA_W-1:0] mainMem [0:255];
  logic [7:0]        flashMem [0:1023];

  initial begin
    int          i;
    logic [63:0] idx;

    mainRdata_o  = '0;
    flashRdata_o = '0;
    // Fill patterns built from the full index
    for (i = 0; i < 256; i++) begin
      idx        = i;
      mainMem[i] = 64'hC0DE_0000_0000_0000 | (idx * 64'h0001_0003_0005_0007);
    end
    for (i = 0; i < 1024; i++) begin
      idx         = i;
      flashMem[i] = idx[7:0] ^ {idx[9:8], 6'h15};
    end
  end

  // Main memory, one word per strobe
  always @(posedge clk) begin
    if (mainReqValid_i) begin
      if (mainReq_i.write) begin
        mainMem[mainReq_i.wordAddr[7:0]] <= mainReq_i.wdata;
      end else begin
        mainRdata_o <= mainMem[mainReq_i.wordAddr[7:0]];
      end
    end
  end

  // Flash, one byte per strobe
  always @(posedge clk) begin
    if (flashReqValid_i) begin
      if (flashReq_i.write) begin
        flashMem[flashReq_i.addr[9:0]] <= flashReq_i.wdata;
      end else begin
        flashRdata_o <= flashMem[flashReq_i.addr[9:0]];
      end
    end
  end

endmodule

//--- test/sysDriverCtrl_tb.sv
//--------------------------------------------------------------------------
// System driver control testbench
// Directed tests of flag ranges, command bits, main-memory and flash
// backdoor access and range errors, against a flag-vector model
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module sysDriverCtrl_tb;

  import sysDrvPkg::*;

  logic              clk;
  logic              reset_i;
  logic              cmdValid;
  cmd_t              cmd;
  logic              rspValid;
  rsp_t              rsp;
  ctrlFlags_t        ctrl;
  logic              mainReqValid;
  mainMemReq_t       mainReq;
  logic [DATA_W-1:0] mainRdata;
  logic              flashReqValid;
  flashReq_t         flashReq;
  logic [7:0]        flashRdata;

  // Model state and last response
  logic [63:0]       rngState;
  logic [FLAG_W-1:0] flagModel;
  ctrlFlags_t        ctrlModel;
  rsp_t              lastRsp;
  int                lastCycles;

  tbClock clock_inst (
    .clk (clk)
  );

  memModels memModels_inst (
    .clk             (clk),
    .mainReqValid_i  (mainReqValid),
    .mainReq_i       (mainReq),
    .mainRdata_o     (mainRdata),
    .flashReqValid_i (flashReqValid),
    .flashReq_i      (flashReq),
    .flashRdata_o    (flashRdata)
  );

  sysDriverCtrl sysDriverCtrl_inst (
    .clk             (clk),
    .reset_i         (reset_i),
    .cmdValid_i      (cmdValid),
    .cmd_i           (cmd),
    .rspValid_o      (rspValid),
    .rsp_o           (rsp),
    .ctrl_o          (ctrl),
    .mainReqValid_o  (mainReqValid),
    .mainReq_o       (mainReq),
    .mainRdata_i     (mainRdata),
    .flashReqValid_o (flashReqValid),
    .flashReq_o      (flashReq),
    .flashRdata_i    (flashRdata)
  );

  //------------------------------------------------------------------------
  // Helpers
  //------------------------------------------------------------------------
  // Xorshift64 step
  function logic [63:0] nextRandom();
    rngState = rngState ^ (rngState << 13);
    rngState = rngState ^ (rngState >> 7);
    rngState = rngState ^ (rngState << 17);
    return rngState;
  endfunction

  // Ones at bits lsb to msb
  function automatic logic [63:0] rangeMask(input int msb, input int lsb);
    logic [63:0] m;
    m = '0;
    for (int i = 0; i < 64; i++) begin
      if (i >= lsb && i <= msb) m[i] = 1'b1;
    end
    return m;
  endfunction

  function automatic logic [63:0] commandMask();
    logic [63:0] m;
    m = '0;
    for (int i = FLG_SET_BACKDOOR_SEL; i <= FLG_SPI_LOOPBACK; i++) begin
      m[i] = 1'b1;
    end
    return m;
  endfunction

  task automatic reportFailure(input string reason);
    $display("%s", reason);
    $display("** FAIL **");
    $fatal(1, "stopped at first error");
  endtask

  task automatic checkValue(input string name, input logic [63:0] got,
                            input logic [63:0] exp);
    assert (got === exp) else
      reportFailure($sformatf("ERR t=%0t %s got=0x%0h exp=0x%0h", $time, name, got, exp));
  endtask

  task automatic checkCtrl();
    checkValue("ctrl_o", {58'b0, ctrl}, {58'b0, ctrlModel});
  endtask

  // Reference flag update, command bits in their fixed order
  task automatic modelFlagWrite(input int msb, input int lsb, input logic [63:0] data);
    logic [63:0] v;
    v = (flagModel & ~rangeMask(msb, lsb)) | ((data << lsb) & rangeMask(msb, lsb));
    if (v[FLG_SET_BACKDOOR_SEL]) ctrlModel.backdoorSel = v[PAT_LO];
    if (v[FLG_GET_BACKDOOR_SEL]) v[PAT_HI:PAT_LO] = {15'b0, ctrlModel.backdoorSel};
    if (v[FLG_SET_PROG_LOADED]) ctrlModel.programLoaded = v[PAT_LO];
    if (v[FLG_DIS_MEM_LOG]) begin
      ctrlModel.wrTrace = 1'b0;
      ctrlModel.rdTrace = 1'b0;
    end
    if (v[FLG_EN_MEM_LOG]) begin
      ctrlModel.wrTrace = 1'b1;
      ctrlModel.rdTrace = 1'b1;
    end
    if (v[FLG_EN_MEMWR_LOG]) ctrlModel.wrTrace = 1'b1;
    if (v[FLG_EN_MEMRD_LOG]) ctrlModel.rdTrace = 1'b1;
    if (v[FLG_UART_LOOPBACK]) ctrlModel.uartLoopback = v[PAT_LO];
    if (v[FLG_SPI_LOOPBACK]) ctrlModel.spiLoopback = v[PAT_LO];
    flagModel = v & ~commandMask();
  endtask

  // Strobe one command, wait for the response pulse
  task automatic runCmd(input opcode_e opcode, input logic [31:0] addr, input int msb,
                        input int lsb, input logic [63:0] data);
    int cycles;
    cmdValid   = 1'b1;
    cmd.opcode = opcode;
    cmd.addr   = addr;
    cmd.msb    = msb[5:0];
    cmd.lsb    = lsb[5:0];
    cmd.data   = data;
    @(posedge clk);
    #1;
    cmdValid = 1'b0;
    cycles   = 1;
    while (!rspValid && cycles < 50) begin
      @(posedge clk);
      #1;
      cycles++;
    end
    assert (rspValid) else
      reportFailure("no response within 50 cycles of the command strobe");
    lastRsp    = rsp;
    lastCycles = cycles;
  endtask

  task automatic flagWrite(input int msb, input int lsb, input logic [63:0] data);
    runCmd(OP_FLAG_WRITE, '0, msb, lsb, data);
    modelFlagWrite(msb, lsb, data);
    checkValue("rsp_o.err", lastRsp.err, 0);
    checkValue("flag write latency", lastCycles, 3);
    checkCtrl();
  endtask

  task automatic flagRead(input int msb, input int lsb, output logic [63:0] value);
    runCmd(OP_FLAG_READ, '0, msb, lsb, '0);
    checkValue("rsp_o.err", lastRsp.err, 0);
    checkValue("flag read latency", lastCycles, 3);
    value = lastRsp.data;
  endtask

  // Range read against the model, bit by bit
  task automatic checkFlagRange(input int msb, input int lsb);
    logic [63:0] got;
    logic [63:0] exp;
    exp = '0;
    for (int i = lsb; i <= msb; i++) exp[i-lsb] = flagModel[i];
    flagRead(msb, lsb, got);
    checkValue("rsp_o.data", got, exp);
  endtask

  //------------------------------------------------------------------------
  // Tests
  //------------------------------------------------------------------------
  task automatic testResetValues();
    logic [63:0] value;
    checkCtrl();
    flagRead(63, 0, value);
    checkValue("rsp_o.data", value, 0);
  endtask

  task automatic testFlagRanges();
    logic [63:0] r;
    logic [63:0] data;
    logic [63:0] value;
    int          lsb;
    int          msb;
    for (int k = 0; k < 8; k++) begin
      r    = nextRandom();
      data = nextRandom();
      // Alternate between the fields below and above the command bits
      if (k % 2 == 0) begin
        lsb = r[31:0] % 32;
        msb = lsb + (r[63:32] % (32 - lsb));
      end else begin
        lsb = 41 + (r[31:0] % 23);
        msb = lsb + (r[63:32] % (64 - lsb));
      end
      flagWrite(msb, lsb, data);
      flagRead(msb, lsb, value);
      checkValue("rsp_o.data", value, data & rangeMask(msb - lsb, 0));
      checkFlagRange(63, 0);
    end
  endtask

  task automatic testCommandBits();
    logic [63:0] value;
    // Select flash, then report the select in the pattern field
    flagWrite(32, 0, (64'h1 << 32) | 64'h1);
    checkValue("ctrl_o.backdoorSel", ctrl.backdoorSel, 1);
    // Pattern field with bit 0 low and the upper bits high
    flagWrite(PAT_HI, PAT_LO, 64'hFFFE);
    flagWrite(33, 33, 64'h1);
    flagRead(PAT_HI, PAT_LO, value);
    checkValue("pattern field", value, 1);
    checkFlagRange(63, 0);
    flagWrite(34, 0, (64'h1 << 34) | 64'h1);
    checkValue("ctrl_o.programLoaded", ctrl.programLoaded, 1);
    checkFlagRange(63, 0);
    // Trace levels
    flagWrite(37, 37, 64'h1);
    flagWrite(35, 35, 64'h1);
    flagWrite(38, 38, 64'h1);
    flagWrite(35, 35, 64'h1);
    // Disable and enable together, enable wins
    flagWrite(36, 35, 64'h3);
    checkValue("ctrl_o.wrTrace", ctrl.wrTrace, 1);
    checkValue("ctrl_o.rdTrace", ctrl.rdTrace, 1);
    // Loopbacks off with pattern bit 0, then both on again
    flagWrite(39, 0, 64'h1 << 39);
    checkValue("ctrl_o.uartLoopback", ctrl.uartLoopback, 0);
    flagWrite(40, 40, 64'h1);
    checkValue("ctrl_o.spiLoopback", ctrl.spiLoopback, 0);
    flagWrite(0, 0, 64'h1);
    flagWrite(40, 39, 64'h3);
    checkValue("ctrl_o.spiLoopback", ctrl.spiLoopback, 1);
    flagRead(FLG_SPI_LOOPBACK, FLG_SET_BACKDOOR_SEL, value);
    checkValue("command bits", value, 0);
    checkFlagRange(63, 0);
    // Back to main memory
    flagWrite(32, 0, 64'h1 << 32);
  endtask

  task automatic testMainMemory();
    logic [31:0] addrs [0:3];
    logic [63:0] words [0:3];
    logic [63:0] r;
    checkValue("ctrl_o.backdoorSel", ctrl.backdoorSel, 0);
    for (int k = 0; k < 4; k++) begin
      r        = nextRandom();
      addrs[k] = k * 64 + (r % 64);
      words[k] = nextRandom();
      runCmd(OP_MEM_WRITE, addrs[k], 0, 0, words[k]);
      checkValue("rsp_o.err", lastRsp.err, 0);
      checkValue("mainMem", memModels_inst.mainMem[addrs[k] >> 3], words[k]);
    end
    for (int k = 0; k < 4; k++) begin
      runCmd(OP_MEM_READ, addrs[k], 0, 0, '0);
      checkValue("rsp_o.err", lastRsp.err, 0);
      checkValue("rsp_o.data", lastRsp.data, words[k]);
    end
  endtask

  task automatic testFlash();
    logic [31:0] addr;
    logic [63:0] data;
    logic [63:0] r;
    flagWrite(32, 0, (64'h1 << 32) | 64'h1);
    checkValue("ctrl_o.backdoorSel", ctrl.backdoorSel, 1);
    for (int k = 0; k < 3; k++) begin
      r    = nextRandom();
      addr = 512 + k * 16 + (r % 8);
      data = nextRandom();
      runCmd(OP_MEM_WRITE, addr, 0, 0, data);
      checkValue("rsp_o.err", lastRsp.err, 0);
      // Little endian, byte 0 at the base address
      for (int i = 0; i < 8; i++) begin
        checkValue("flashMem", memModels_inst.flashMem[addr + i], data[8*i +: 8]);
      end
      runCmd(OP_MEM_READ, addr, 0, 0, '0);
      checkValue("rsp_o.data", lastRsp.data, data);
    end
  endtask

  task automatic testBadRange();
    // Would set the select bit if it were accepted
    runCmd(OP_FLAG_WRITE, '0, 0, 32, 64'h1);
    checkValue("rsp_o.err", lastRsp.err, 1);
    checkValue("error latency", lastCycles, 3);
    checkCtrl();
    runCmd(OP_FLAG_READ, '0, 5, 20, '0);
    checkValue("rsp_o.err", lastRsp.err, 1);
    checkFlagRange(63, 0);
  endtask

  //------------------------------------------------------------------------
  // Sequence
  //------------------------------------------------------------------------
  initial begin
    reset_i    = 1'b1;
    cmdValid   = 1'b0;
    cmd        = '0;
    rngState   = 64'd18;
    flagModel  = '0;
    lastRsp    = '0;
    lastCycles = 0;
    ctrlModel               = '0;
    ctrlModel.uartLoopback  = 1'b1;
    ctrlModel.spiLoopback   = 1'b1;

    repeat (8) @(posedge clk);
    #1;
    reset_i = 1'b0;

    testResetValues();
    testFlagRanges();
    testCommandBits();
    testMainMemory();
    testFlash();
    testBadRange();

    $display("** PASS **");
    $finish;
  end

endmodule

//--- test/tbClock.sv
//--------------------------------------------------------------------------
// Testbench clock source
// Free-running clock with a 4 ns period
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module tbClock (
  output logic clk
);

  initial begin
    clk = 1'b0;
  end

  // Half period of 2 ns
  always #2 clk = ~clk;

endmodule
